//--- layers_pkg.sv
`default_nettype none

package layers_pkg;

    // datapath sizes
    localparam int depth_nb  = 2;
    localparam int group_nb  = 2;
    localparam int img_width = 8;
    localparam int ker_width = 8;
    localparam int num_width = img_width + ker_width + 1;

    // saturation limits of a result word
    localparam int img_max = 2 ** (img_width - 1) - 1;
    localparam int img_min = -(2 ** (img_width - 1));

    // configuration bus and the layer register layout
    localparam int cfg_dwidth = 32;
    localparam int cfg_awidth = 5;

    localparam logic [cfg_awidth-1:0] cfg_layers = 5'd1;

    localparam int cfg_bypass_bit  = 16;
    localparam int cfg_pool_lsb    = 8;
    localparam int cfg_pool_width  = 8;
    localparam int cfg_shift_lsb   = 0;
    localparam int cfg_shift_width = 8;

    typedef logic signed [img_width-1:0] img_t;
    typedef logic signed [ker_width-1:0] ker_t;
    typedef logic signed [num_width-1:0] num_t;

    typedef num_t [depth_nb-1:0]               lane_num_t;
    typedef img_t [depth_nb-1:0]               lane_img_t;
    typedef num_t [depth_nb-1:0][group_nb-1:0] group_num_t;

    // upstream side, image accumulation
    typedef enum logic [1:0] {
        up_reset,
        up_ready,
        up_done,
        up_clear
    } up_state_t;

    // downstream side, pooling and post operations
    typedef enum logic [2:0] {
        dn_reset,
        dn_ready,
        dn_add,
        dn_pool,
        dn_ops,
        dn_clear
    } dn_state_t;

endpackage

`default_nettype wire

//--- ops_ctrl_if.sv
`timescale 1ns/10ps
`default_nettype none

interface ops_ctrl_if import layers_pkg::*; ();

    logic                       mac_clear;
    logic                       mac_en;
    logic                       hold_en;
    logic                       pool_restart;
    logic                       pool_en;
    logic                       act_en;
    logic                       result_en;
    logic                       bypass;
    logic [cfg_shift_width-1:0] shift;

    modport ctrl (
        output mac_clear, mac_en, hold_en,
        output pool_restart, pool_en,
        output act_en, result_en,
        output bypass, shift
    );

    modport ops (
        input mac_clear, mac_en, hold_en,
        input pool_restart, pool_en,
        input act_en, result_en,
        input bypass, shift
    );

endinterface

`default_nettype wire

//--- layer_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module layer_ctrl import layers_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [cfg_dwidth-1:0] cfg_data,
    input  logic [cfg_awidth-1:0] cfg_addr,
    input  logic                  cfg_valid,
    input  logic                  image_val,
    input  logic                  image_last,
    output logic                  image_rdy,
    output logic                  kernel_rdy,
    output logic                  result_val,
    input  logic                  result_rdy,
    ops_ctrl_if.ctrl              ctl
);

    up_state_t                  up_state;
    up_state_t                  up_state_nx;
    dn_state_t                  dn_state;
    dn_state_t                  dn_state_nx;

    logic                       bypass;
    logic [cfg_pool_width-1:0]  pool_nb;
    logic [cfg_shift_width-1:0] shift;
    logic [cfg_pool_width-1:0]  pool_cnt;

    logic                       accept;
    logic                       pool_last;
    logic                       hold_en;
    logic                       act_en;
    logic                       result_en;

    // layer configuration, written only while idle
    always_ff @(posedge clk) begin
        if (rst) begin
            bypass  <= 1'b0;
            pool_nb <= '0;
            shift   <= '0;
        end else if (cfg_valid && (cfg_addr == cfg_layers)) begin
            bypass  <= cfg_data[cfg_bypass_bit];
            pool_nb <= cfg_data[cfg_pool_lsb +: cfg_pool_width];
            shift   <= cfg_data[cfg_shift_lsb +: cfg_shift_width];
        end
    end

    assign accept     = image_val && image_rdy;
    assign image_rdy  = (up_state == up_ready);
    assign result_val = (dn_state == dn_clear);
    assign pool_last  = (pool_cnt >= pool_nb);

    always_ff @(posedge clk) begin
        if (rst) begin
            up_state <= up_reset;
            dn_state <= dn_reset;
        end else begin
            up_state <= up_state_nx;
            dn_state <= dn_state_nx;
        end
    end

    // upstream waits in up_clear until downstream takes the hold register
    always_comb begin
        up_state_nx = up_state;
        case (up_state)
            up_reset: up_state_nx = up_ready;
            up_ready: begin
                if (accept && image_last)
                    up_state_nx = up_done;
            end
            up_done: begin
                if (hold_en)
                    up_state_nx = up_clear;
            end
            up_clear: begin
                if (dn_state == dn_ready)
                    up_state_nx = up_reset;
            end
            default: up_state_nx = up_reset;
        endcase
    end

    always_comb begin
        dn_state_nx = dn_state;
        case (dn_state)
            dn_reset: dn_state_nx = dn_ready;
            dn_ready: begin
                if (up_state == up_clear)
                    dn_state_nx = dn_add;
            end
            dn_add:  dn_state_nx = dn_pool;
            // more frames in this window go back for the next handover
            dn_pool: dn_state_nx = pool_last ? dn_ops : dn_ready;
            dn_ops: begin
                if (result_en)
                    dn_state_nx = dn_clear;
            end
            dn_clear: begin
                if (result_rdy)
                    dn_state_nx = dn_reset;
            end
            default: dn_state_nx = dn_reset;
        endcase
    end

    // kernel strobe follows each accepted beat by one cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            kernel_rdy <= 1'b0;
            hold_en    <= 1'b0;
            act_en     <= 1'b0;
            result_en  <= 1'b0;
        end else begin
            kernel_rdy <= accept;
            hold_en    <= kernel_rdy && (up_state == up_done);
            act_en     <= (dn_state == dn_pool) && pool_last;
            result_en  <= act_en;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || (dn_state == dn_reset))
            pool_cnt <= '0;
        else if (dn_state == dn_pool)
            pool_cnt <= pool_last ? '0 : pool_cnt + 1'b1;
    end

    assign ctl.mac_clear    = (up_state == up_reset);
    assign ctl.mac_en       = kernel_rdy;
    assign ctl.hold_en      = hold_en;
    assign ctl.pool_restart = (dn_state == dn_reset);
    assign ctl.pool_en      = (dn_state == dn_pool);
    assign ctl.act_en       = act_en;
    assign ctl.result_en    = result_en;
    assign ctl.bypass       = bypass;
    assign ctl.shift        = shift;

    a_pool_cnt_range: assert property (
        @(posedge clk) disable iff (rst) pool_cnt <= pool_nb
    );

    // a stalled result keeps its register untouched until taken
    a_result_stall: assert property (
        @(posedge clk) disable iff (rst)
        (result_val && !result_rdy) |=> (result_val && !result_en)
    );

    a_image_rdy_fall: assert property (
        @(posedge clk) disable iff (rst)
        $fell(image_rdy) |-> $past(image_val && image_last)
    );

endmodule

`default_nettype wire

//--- mac_array.sv
`timescale 1ns/10ps
`default_nettype none

module mac_array import layers_pkg::*; (
    input  logic                              clk,
    input  img_t [group_nb-1:0]               image_bus,
    input  ker_t [depth_nb-1:0][group_nb-1:0] kernel_bus,
    ops_ctrl_if.ops                           ctl,
    output group_num_t                        sums
);

    img_t [group_nb-1:0] image_q;
    group_num_t          acc;

    // the beat taken on the accept edge lines up with its kernel a cycle later
    always_ff @(posedge clk) begin
        image_q <= image_bus;
    end

    always_ff @(posedge clk) begin
        for (int l = 0; l < depth_nb; l++) begin
            for (int g = 0; g < group_nb; g++) begin
                if (ctl.mac_clear)
                    acc[l][g] <= '0;
                else if (ctl.mac_en)
                    // wraps at num_width
                    acc[l][g] <= acc[l][g]
                        + num_t'(image_q[g]) * num_t'(kernel_bus[l][g]);
            end
        end
    end

    // frame sums parked here so the next frame can start accumulating
    always_ff @(posedge clk) begin
        if (ctl.hold_en)
            sums <= acc;
    end

endmodule

`default_nettype wire

//--- reduce_pool.sv
`timescale 1ns/10ps
`default_nettype none

module reduce_pool import layers_pkg::*; (
    input  logic       clk,
    input  group_num_t sums,
    ops_ctrl_if.ops    ctl,
    output lane_num_t  pooled
);

    lane_num_t total;
    lane_num_t frame_sum;
    logic      first;

    // adder tree over the group members of each lane
    always_comb begin
        for (int l = 0; l < depth_nb; l++) begin
            total[l] = '0;
            for (int g = 0; g < group_nb; g++)
                total[l] = total[l] + sums[l][g];
        end
    end

    always_ff @(posedge clk) begin
        frame_sum <= total;
    end

    // first frame of a window is taken without a compare
    always_ff @(posedge clk) begin
        if (ctl.pool_restart)
            first <= 1'b1;
        else if (ctl.pool_en)
            first <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (ctl.pool_en) begin
            for (int l = 0; l < depth_nb; l++) begin
                if (first || ($signed(frame_sum[l]) > $signed(pooled[l])))
                    pooled[l] <= frame_sum[l];
            end
        end
    end

    a_pool_exclusive: assert property (
        @(posedge clk) !(ctl.pool_en && ctl.pool_restart)
    );

endmodule

`default_nettype wire

//--- activation.sv
`timescale 1ns/10ps
`default_nettype none

module activation import layers_pkg::*; (
    input  logic                clk,
    input  lane_num_t           pooled,
    input  ker_t [depth_nb-1:0] bias_bus,
    ops_ctrl_if.ops             ctl,
    output lane_img_t           result
);

    lane_num_t biased;
    lane_num_t relu_q;
    lane_num_t shifted;

    always_comb begin
        for (int l = 0; l < depth_nb; l++) begin
            biased[l]  = pooled[l] + num_t'(bias_bus[l]);
            shifted[l] = $signed(relu_q[l]) >>> ctl.shift;
        end
    end

    // negative values clamp to zero unless relu is bypassed
    always_ff @(posedge clk) begin
        if (ctl.act_en) begin
            for (int l = 0; l < depth_nb; l++)
                relu_q[l] <= (!ctl.bypass && biased[l][num_width-1]) ? '0 : biased[l];
        end
    end

    always_ff @(posedge clk) begin
        if (ctl.result_en) begin
            for (int l = 0; l < depth_nb; l++) begin
                if ($signed(shifted[l]) > img_max)
                    result[l] <= img_t'(img_max);
                else if ($signed(shifted[l]) < img_min)
                    result[l] <= img_t'(img_min);
                else
                    result[l] <= shifted[l][img_width-1:0];
            end
        end
    end

endmodule

`default_nettype wire

//--- layers.sv
`timescale 1ns/10ps
`default_nettype none

module layers import layers_pkg::*; (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic [cfg_dwidth-1:0]                 cfg_data,
    input  logic [cfg_awidth-1:0]                 cfg_addr,
    input  logic                                  cfg_valid,
    input  logic [depth_nb*ker_width-1:0]         bias_bus,
    input  logic [depth_nb*group_nb*ker_width-1:0] kernel_bus,
    output logic                                  kernel_rdy,
    input  logic [group_nb*img_width-1:0]         image_bus,
    input  logic                                  image_last,
    input  logic                                  image_val,
    output logic                                  image_rdy,
    output logic [depth_nb*img_width-1:0]         result_bus,
    output logic                                  result_val,
    input  logic                                  result_rdy
);

    group_num_t sums;
    lane_num_t  pooled;

    ops_ctrl_if ctl ();

    layer_ctrl layer_ctrl_ (
        .clk        (clk),
        .rst        (rst),
        .cfg_data   (cfg_data),
        .cfg_addr   (cfg_addr),
        .cfg_valid  (cfg_valid),
        .image_val  (image_val),
        .image_last (image_last),
        .image_rdy  (image_rdy),
        .kernel_rdy (kernel_rdy),
        .result_val (result_val),
        .result_rdy (result_rdy),
        .ctl        (ctl.ctrl)
    );

    // flat buses map lane major, then group member
    mac_array mac_array_ (
        .clk        (clk),
        .image_bus  (image_bus),
        .kernel_bus (kernel_bus),
        .ctl        (ctl.ops),
        .sums       (sums)
    );

    reduce_pool reduce_pool_ (
        .clk    (clk),
        .sums   (sums),
        .ctl    (ctl.ops),
        .pooled (pooled)
    );

    activation activation_ (
        .clk      (clk),
        .pooled   (pooled),
        .bias_bus (bias_bus),
        .ctl      (ctl.ops),
        .result   (result_bus)
    );

endmodule

`default_nettype wire

//--- tb_layers.sv
`timescale 1ns/10ps
`default_nettype none

module tb_layers import layers_pkg::*; ();

    localparam int n_win      = 6;
    localparam int max_frames = 3;
    localparam int max_beats  = 2;
    localparam int sat_hi     = (1 << (img_width - 1)) - 1;
    localparam int sat_lo     = -(1 << (img_width - 1));

    logic                                   clk;
    logic                                   rst;
    logic [cfg_dwidth-1:0]                  cfg_data;
    logic [cfg_awidth-1:0]                  cfg_addr;
    logic                                   cfg_valid;
    logic [depth_nb*ker_width-1:0]          bias_bus;
    logic [depth_nb*group_nb*ker_width-1:0] kernel_bus;
    logic                                   kernel_rdy;
    logic [group_nb*img_width-1:0]          image_bus;
    logic                                   image_last;
    logic                                   image_val;
    logic                                   image_rdy;
    logic [depth_nb*img_width-1:0]          result_bus;
    logic                                   result_val;
    logic                                   result_rdy;

    // one row per pooling window
    logic [cfg_dwidth-1:0]                  cfg_tab   [n_win];
    int                                     beat_tab  [n_win];
    int                                     frame_tab [n_win];
    int                                     stall_tab [n_win];
    logic [depth_nb*ker_width-1:0]          bias_tab  [n_win];
    logic [depth_nb*group_nb*ker_width-1:0] ker_tab   [n_win][max_beats];
    logic [group_nb*img_width-1:0]          img_tab   [n_win][max_frames][max_beats];
    lane_img_t                              exp_tab   [n_win];

    logic [31:0] lcg_state;
    int          cycles;
    int          cycle_limit;
    int          total_beats;

    layers i_layers (
        .clk        (clk),
        .rst        (rst),
        .cfg_data   (cfg_data),
        .cfg_addr   (cfg_addr),
        .cfg_valid  (cfg_valid),
        .bias_bus   (bias_bus),
        .kernel_bus (kernel_bus),
        .kernel_rdy (kernel_rdy),
        .image_bus  (image_bus),
        .image_last (image_last),
        .image_val  (image_val),
        .image_rdy  (image_rdy),
        .result_bus (result_bus),
        .result_val (result_val),
        .result_rdy (result_rdy)
    );

    always #20 clk = ~clk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Done: errors found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic compare_img(input string name, input lane_img_t got, input lane_img_t exp);
        if (got !== exp)
            abort_run($sformatf("Mismatch at %0t ns: %s got %h expected %h",
                $time, name, got, exp));
    endtask

    task automatic compare_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
            abort_run($sformatf("Mismatch at %0t ns: %s got %b expected %b",
                $time, name, got, exp));
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit)
            abort_run("Timeout: the tests did not finish within the cycle limit");
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic logic [7:0] rand_byte();
        lcg_state = lcg_next(lcg_state);
        return lcg_state[23:16];
    endfunction

    // two's complement wrap at the accumulator width
    function automatic int wrap_num(input int x);
        logic signed [num_width-1:0] t;
        t = x[num_width-1:0];
        return int'(t);
    endfunction

    // max over the frames, then bias, relu, shift and saturate
    function automatic lane_img_t expected_result(input int w);
        lane_img_t res;
        int        l;
        int        f;
        int        b;
        int        g;
        int        best;
        int        frame_sum;
        int        v;
        img_t      px;
        ker_t      kw;
        ker_t      bias;
        for (l = 0; l < depth_nb; l++) begin
            best = 0;
            for (f = 0; f < frame_tab[w]; f++) begin
                frame_sum = 0;
                for (b = 0; b < beat_tab[w]; b++) begin
                    for (g = 0; g < group_nb; g++) begin
                        px = img_tab[w][f][b][g*img_width +: img_width];
                        kw = ker_tab[w][b][(l*group_nb+g)*ker_width +: ker_width];
                        frame_sum += int'(px) * int'(kw);
                    end
                end
                frame_sum = wrap_num(frame_sum);
                if (f == 0 || frame_sum > best)
                    best = frame_sum;
            end
            bias = bias_tab[w][l*ker_width +: ker_width];
            v = wrap_num(best + int'(bias));
            if (!cfg_tab[w][cfg_bypass_bit] && v < 0)
                v = 0;
            v = v >>> cfg_tab[w][cfg_shift_lsb +: cfg_shift_width];
            if (v > sat_hi)
                v = sat_hi;
            else if (v < sat_lo)
                v = sat_lo;
            res[l] = v[img_width-1:0];
        end
        return res;
    endfunction

    task automatic set_window(input int w, input logic [cfg_dwidth-1:0] cfg, input int beats,
                              input int frames, input logic [15:0] bias, input int stall);
        cfg_tab[w]   = cfg;
        beat_tab[w]  = beats;
        frame_tab[w] = frames;
        bias_tab[w]  = bias;
        stall_tab[w] = stall;
    endtask

    task automatic fill_random(input int w);
        int f;
        int b;
        int k;
        for (b = 0; b < beat_tab[w]; b++)
            for (k = 0; k < depth_nb * group_nb; k++)
                ker_tab[w][b][k*ker_width +: ker_width] = rand_byte();
        for (f = 0; f < frame_tab[w]; f++)
            for (b = 0; b < beat_tab[w]; b++)
                for (k = 0; k < group_nb; k++)
                    img_tab[w][f][b][k*img_width +: img_width] = rand_byte();
    endtask

    task automatic build_table();
        int w;
        // single frame, positive sums
        set_window(0, 32'h0000_0000, 2, 1, 16'h02_01, 0);
        ker_tab[0][0]    = 32'h02_03_01_02;
        ker_tab[0][1]    = 32'h01_01_01_01;
        img_tab[0][0][0] = 16'h04_05;
        img_tab[0][0][1] = 16'h03_02;
        // negative sums kept by the relu bypass
        set_window(1, 32'h0001_0000, 1, 1, 16'h00_00, 0);
        ker_tab[1][0]    = 32'hFE_FD_FF_FE;
        img_tab[1][0][0] = 16'h04_05;
        // same sums clamped to zero
        set_window(2, 32'h0000_0001, 1, 1, 16'hFF_01, 0);
        ker_tab[2][0]    = 32'hFE_FD_FF_FE;
        img_tab[2][0][0] = 16'h04_05;
        set_window(3, 32'h0000_0208, 2, 3, 16'h10_F0, 0);
        fill_random(3);
        // both saturation limits, result held back for a while
        set_window(4, 32'h0001_0200, 1, 3, 16'h00_00, 6);
        ker_tab[4][0]    = 32'h80_80_7F_7F;
        img_tab[4][0][0] = 16'h7F_7F;
        img_tab[4][1][0] = 16'h10_20;
        img_tab[4][2][0] = 16'h40_40;
        set_window(5, 32'h0001_0107, 2, 2, 16'h05_FB, 0);
        fill_random(5);
        total_beats = 0;
        for (w = 0; w < n_win; w++) begin
            exp_tab[w] = expected_result(w);
            total_beats += beat_tab[w] * frame_tab[w];
        end
        cycle_limit = total_beats * 20 + 200;
    endtask

    task automatic write_cfg(input logic [cfg_dwidth-1:0] data);
        cfg_data  = data;
        cfg_addr  = cfg_layers;
        cfg_valid = 1'b1;
        @(negedge clk);
        cfg_valid = 1'b0;
    endtask

    // every beat is followed by its kernel in the next cycle
    task automatic send_frame(input int w, input int f);
        int b;
        for (b = 0; b < beat_tab[w]; b++) begin
            image_val  = 1'b1;
            image_bus  = img_tab[w][f][b];
            image_last = (b == beat_tab[w] - 1);
            while (!image_rdy) begin
                compare_bit("kernel_rdy", kernel_rdy, 1'b0);
                @(negedge clk);
            end
            @(negedge clk);
            compare_bit("kernel_rdy", kernel_rdy, 1'b1);
            kernel_bus = ker_tab[w][b];
            image_val  = 1'b0;
            image_last = 1'b0;
        end
        compare_bit("image_rdy", image_rdy, 1'b0);
        @(negedge clk);
        compare_bit("kernel_rdy", kernel_rdy, 1'b0);
        compare_bit("image_rdy", image_rdy, 1'b0);
    endtask

    task automatic collect_result(input int w);
        lane_img_t held;
        result_rdy = (stall_tab[w] == 0);
        while (!result_val)
            @(negedge clk);
        compare_img("result_bus", result_bus, exp_tab[w]);
        held = result_bus;
        repeat (stall_tab[w]) begin
            @(negedge clk);
            compare_bit("result_val", result_val, 1'b1);
            compare_img("result_bus", result_bus, held);
        end
        result_rdy = 1'b1;
        @(negedge clk);
        compare_bit("result_val", result_val, 1'b0);
    endtask

    initial begin
        int w;
        int f;
        int waited;
        clk         = 1'b0;
        rst         = 1'b1;
        cfg_data    = '0;
        cfg_addr    = '0;
        cfg_valid   = 1'b0;
        bias_bus    = '0;
        kernel_bus  = '0;
        image_bus   = '0;
        image_last  = 1'b0;
        image_val   = 1'b0;
        result_rdy  = 1'b1;
        cycles      = 0;
        lcg_state   = 32'h5102;
        build_table();

        repeat (4) @(negedge clk);
        compare_bit("image_rdy", image_rdy, 1'b0);
        compare_bit("kernel_rdy", kernel_rdy, 1'b0);
        compare_bit("result_val", result_val, 1'b0);
        rst = 1'b0;
        waited = 0;
        while (!image_rdy) begin
            if (waited == 4)
                abort_run("image_rdy did not rise after reset");
            @(negedge clk);
            waited++;
        end

        for (w = 0; w < n_win; w++) begin
            bias_bus = bias_tab[w];
            write_cfg(cfg_tab[w]);
            for (f = 0; f < frame_tab[w]; f++)
                send_frame(w, f);
            collect_result(w);
        end

        $display("Done: no errors");
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
layers_pkg.sv
ops_ctrl_if.sv
layer_ctrl.sv
mac_array.sv
reduce_pool.sv
activation.sv
layers.sv
tb_layers.sv

//--- Makefile
TOOL  = verilator
FLAGS = --binary --timing --assert -Wno-fatal
TOP   = tb_layers
FLIST = sim.f
BUILD = obj_dir
LOG   = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FLIST)

run: compile
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "Done: no errors" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
